/* source/stoch_defines.svh */
`ifndef STOCH_DEFINES_SVH
`define STOCH_DEFINES_SVH

// Probability and counter word
`define VALUE_W     9
`define VALUE_MAX   511    // Upper saturation limit of every integrator

// Serial framing, 9 data bits then one dummy
`define FRAME_LEN   10

// Fibonacci LFSR
`define LFSR_W      31
`define LFSR_SEED   134995
`define LFSR_TAP_HI 30     // Feedback taps, x^31 + x^28 + 1
`define LFSR_TAP_LO 27

`endif

/* source/stoch_pkg.sv */
`include "stoch_defines.svh"

package stoch_pkg;

    // One probability or counter value
    typedef logic [`VALUE_W-1:0] value_t;

    // Position inside a serial frame, 0 to FRAME_LEN-1
    typedef logic [$clog2(`FRAME_LEN)-1:0] frame_pos_t;

    typedef logic [`LFSR_W-1:0] lfsr_state_t; // Full LFSR word

    // Random words cut from the LFSR, one per comparator
    typedef struct packed {
        value_t in_a;     // Input a generator
        value_t in_b;     // Input b generator
        value_t integ_a;  // Integrator a generator
        value_t integ_b;
        value_t integ_c;
    } rand_words_t;

    // Captured input probabilities
    typedef struct packed {
        value_t a;
        value_t b;
    } in_values_t;

    typedef struct packed {
        logic a;
        logic b;
    } in_bits_t;  // Serial input pins and input bitstreams

    // Counter values of the chain
    typedef struct packed {
        value_t a;  // ~ t
        value_t b;  // ~ t^2/2
        value_t c;  // ~ t^3/6
    } integ_values_t;

    // Integrator bitstreams, also the serial output pins
    typedef struct packed {
        logic a;
        logic b;
        logic c;
    } integ_bits_t;

endpackage

/* source/frame_control.sv */
`include "stoch_defines.svh"

module frame_control
    import stoch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    output frame_pos_t frame_pos  // Decoded by both serial sides
);

    // Dummy bit slot, wrap point of the frame
    localparam frame_pos_t LAST_POS = frame_pos_t'(`FRAME_LEN - 1);

    // Free-running position counter, 0..9 then back to 0
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            frame_pos <= '0;                   // First edge after release is position 0
        end else if (frame_pos == LAST_POS) begin
            frame_pos <= '0;                   // Wrap after dummy slot
        end else begin
            frame_pos <= frame_pos + 1'b1;
        end
    end

endmodule

/* source/serial_deserializer.sv */
`include "stoch_defines.svh"

module serial_deserializer
    import stoch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  frame_pos_t frame_pos,
    input  in_bits_t   ser_in,     // One bit per channel per clock
    output in_values_t in_values   // Values in effect for the chain
);

    localparam frame_pos_t LAST_POS = frame_pos_t'(`FRAME_LEN - 1);

    in_values_t shift_q;  // Per-channel right-shifting collectors

    // Data slots shift in at the MSB
    // Bit taken at position 0 reaches the LSB after nine shifts
    always_ff @(posedge clk) begin
        if (frame_pos != LAST_POS) begin
            shift_q.a <= {ser_in.a, shift_q.a[`VALUE_W-1:1]};
            shift_q.b <= {ser_in.b, shift_q.b[`VALUE_W-1:1]};
        end
    end

    // Capture on the dummy slot, dummy bit itself dropped
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            in_values <= '0;
        end else if (frame_pos == LAST_POS) begin
            in_values <= shift_q;  // Visible from next cycle
        end
    end

endmodule

/* source/lfsr_source.sv */
`include "stoch_defines.svh"

module lfsr_source
    import stoch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output rand_words_t rand_words  // Five 9-bit slices
);

    lfsr_state_t lfsr_q;
    logic        feedback;

    assign feedback = lfsr_q[`LFSR_TAP_HI] ^ lfsr_q[`LFSR_TAP_LO];

    // Shift toward the MSB, new bit enters at bit 0
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            lfsr_q <= lfsr_state_t'(`LFSR_SEED);  // Nonzero seed
        end else begin
            lfsr_q <= {lfsr_q[`LFSR_W-2:0], feedback};
        end
    end

    // Fixed slices of the one LFSR word
    // First-listed bits go to the MSB side
    assign rand_words.in_a    = lfsr_q[8:0];
    assign rand_words.in_b    = {lfsr_q[5:0], lfsr_q[18:16]};    // Overlaps in_a low bits
    assign rand_words.integ_a = lfsr_q[30:22];                   // Top of register
    assign rand_words.integ_b = {lfsr_q[15:13], lfsr_q[6:1]};
    assign rand_words.integ_c = {lfsr_q[24:19], lfsr_q[14:12]};

    // The slices share bits, so streams are only loosely decorrelated;
    // the chain relies on the differing bit orders rather than
    // disjoint fields

endmodule

/* source/sat_updown_counter.sv */
`include "stoch_defines.svh"

module sat_updown_counter
    import stoch_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   inc,    // Stochastic up bit
    input  logic   dec,    // Stochastic down bit
    output value_t value
);

    localparam value_t MAX_VAL = value_t'(`VALUE_MAX);

    logic at_max;
    logic at_min;

    assign at_max = (value == MAX_VAL);
    assign at_min = (value == '0);

    // One step per clock, both or neither high means hold
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            value <= '0;
        end else if (inc && !dec) begin
            if (!at_max) begin
                value <= value + 1'b1;  // Stops at VALUE_MAX
            end
        end else if (dec && !inc) begin
            if (!at_min) begin
                value <= value - 1'b1;  // Stops at 0, no wrap
            end
        end
    end

endmodule

/* source/integrator_chain.sv */
module integrator_chain
    import stoch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  in_values_t    in_values,
    input  rand_words_t   rand_words,
    output integ_values_t integ_values,
    output logic          sn_c          // Third integrator bitstream
);

    in_bits_t    sn_in;     // Input a and b streams
    integ_bits_t sn_integ;  // Streams of the three counters

    // Input stochastic number generators
    // A bit is 1 with probability value/512
    assign sn_in.a = (in_values.a > rand_words.in_a);
    assign sn_in.b = (in_values.b > rand_words.in_b);

    // First stage integrates input a, gives t
    sat_updown_counter integ_a_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (sn_in.a),
        .dec   (sn_in.b),
        .value (integ_values.a)
    );

    assign sn_integ.a = (integ_values.a > rand_words.integ_a);

    // Second stage integrates stage a stream, gives t^2/2
    sat_updown_counter integ_b_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (sn_integ.a),
        .dec   (sn_in.b),         // Shared b drain
        .value (integ_values.b)
    );

    assign sn_integ.b = (integ_values.b > rand_words.integ_b);

    // Third stage, gives t^3/6
    sat_updown_counter integ_c_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (sn_integ.b),
        .dec   (sn_in.b),
        .value (integ_values.c)
    );

    assign sn_integ.c = (integ_values.c > rand_words.integ_c);

    // All three counters step on the same edge from current values,
    // so a change at the input needs three clocks to reach stage c

    assign sn_c = sn_integ.c;  // Straight to the pin

endmodule

/* source/serial_serializer.sv */
`include "stoch_defines.svh"

module serial_serializer
    import stoch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  frame_pos_t    frame_pos,
    input  integ_values_t integ_values,  // Live counter values
    output integ_bits_t   ser_out        // LSB first, then a 0
);

    localparam frame_pos_t LAST_POS = frame_pos_t'(`FRAME_LEN - 1);

    integ_values_t latch_q;  // Snapshot taken at frame start

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            latch_q <= '0;
            ser_out <= '0;
        end else if (frame_pos == '0) begin
            // Snapshot and bit 0 straight from the live values
            latch_q   <= integ_values;
            ser_out.a <= integ_values.a[0];
            ser_out.b <= integ_values.b[0];
            ser_out.c <= integ_values.c[0];
        end else if (frame_pos == LAST_POS) begin
            ser_out <= '0;                   // Dummy slot
        end else begin
            ser_out.a <= latch_q.a[frame_pos];  // Bits 1..8
            ser_out.b <= latch_q.b[frame_pos];
            ser_out.c <= latch_q.c[frame_pos];
        end
    end

endmodule

/* source/stoch_integrator_top.sv */
module stoch_integrator_top
    import stoch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  in_bits_t    ser_in,   // Serial a and b frames
    output integ_bits_t ser_out,  // Serial counter frames
    output logic        sn_c      // Raw stage c bitstream
);

    frame_pos_t    frame_pos;     // Shared frame timing
    in_values_t    in_values;
    rand_words_t   rand_words;
    integ_values_t integ_values;

    frame_control u_frame_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .frame_pos (frame_pos)
    );

    // Input side
    serial_deserializer u_serial_deserializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .frame_pos (frame_pos),
        .ser_in    (ser_in),
        .in_values (in_values)
    );

    lfsr_source u_lfsr_source (
        .clk        (clk),
        .rst_n      (rst_n),
        .rand_words (rand_words)
    );

    // Three integrators in sequence
    integrator_chain u_integrator_chain (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_values    (in_values),
        .rand_words   (rand_words),
        .integ_values (integ_values),
        .sn_c         (sn_c)
    );

    // Output side, same frame alignment as input
    serial_serializer u_serial_serializer (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_pos    (frame_pos),
        .integ_values (integ_values),
        .ser_out      (ser_out)
    );

endmodule

/* sim/stoch_integrator_properties.sv */
`include "stoch_defines.svh"

module stoch_integrator_properties
    import stoch_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input frame_pos_t  frame_pos,  // Internal frame counter of the top
    input integ_bits_t ser_out,
    input logic        sn_c
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam frame_pos_t LAST_POS = frame_pos_t'(`FRAME_LEN - 1);

    // Outputs settle to 0 once reset has been seen
    a_quiet_in_reset: assert property (@(posedge clk)
        rst_n |=> (ser_out == '0 && !sn_c))
        else $error("outputs not 0 during reset");

    a_dummy_zero: assert property (@(posedge clk) disable iff (rst_n)
        frame_pos == LAST_POS |=> ser_out == '0)  // Dummy slot of each output frame
        else $error("ser_out not 0 in dummy slot");

    a_pos_range: assert property (@(posedge clk)
        frame_pos <= LAST_POS)
        else $error("frame_pos beyond last slot");

endmodule

bind stoch_integrator_top stoch_integrator_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .frame_pos (frame_pos),
    .ser_out   (ser_out),
    .sn_c      (sn_c)
);

/* sim/stoch_integrator_tb.sv */
`include "stoch_defines.svh"

module stoch_integrator_tb
    import stoch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam frame_pos_t LAST_POS = frame_pos_t'(`FRAME_LEN - 1);
    localparam value_t MAX_VAL = value_t'(`VALUE_MAX);
    // Reset, then frames of tests 1 to 6 at their longest
    localparam int TEST_CYCLES = 3 + `FRAME_LEN * (2 + 20 + 60 + 70 + 250 + 6);
    localparam int MAX_CYCLES = TEST_CYCLES * 6 / 5;  // 20% margin

    logic        clk;
    logic        rst_n;
    in_bits_t    ser_in;
    integ_bits_t ser_out;
    logic        sn_c;

    // Reference model state
    value_t        m_shift_a, m_shift_b;
    in_values_t    m_in;
    lfsr_state_t   m_lfsr;
    integ_values_t m_cnt, m_latch;
    integ_bits_t   m_out;
    frame_pos_t    m_pos;

    integ_values_t rx_frame;    // Bits collected from ser_out
    integ_values_t last_frame;  // Last complete output frame
    logic          expect_quiet;
    int            n_checks, n_errors, n_tests, n_cycles;
    integer        seed = 32'heb8b;

    stoch_integrator_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .ser_in  (ser_in),
        .ser_out (ser_out),
        .sn_c    (sn_c)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        n_cycles <= n_cycles + 1;
        if (n_cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Five comparator words cut from one LFSR state, MSB side listed first
    function automatic rand_words_t make_words(input lfsr_state_t s);
        rand_words_t w;
        w.in_a    = s[8:0];
        w.in_b    = {s[5:0], s[18:16]};
        w.integ_a = s[30:22];
        w.integ_b = {s[15:13], s[6:1]};
        w.integ_c = {s[24:19], s[14:12]};
        return w;
    endfunction

    // Saturating step, hold when both or neither
    function automatic value_t step_count(input value_t v, input logic up, input logic down);
        if (up && !down && v != MAX_VAL) return v + value_t'(1);
        if (down && !up && v != '0) return v - value_t'(1);
        return v;
    endfunction

    // Input bits for position k of a frame, dummy 0 at the end
    function automatic in_bits_t frame_bits(input value_t a, input value_t b, input int k);
        in_bits_t bits;
        bits.a = (k < `VALUE_W) ? a[k] : 1'b0;
        bits.b = (k < `VALUE_W) ? b[k] : 1'b0;
        return bits;
    endfunction

    task automatic model_reset();
        m_in   = '0;
        m_lfsr = lfsr_state_t'(`LFSR_SEED);
        m_cnt  = '0;
        m_latch = '0;
        m_out  = '0;
        m_pos  = '0;
    endtask

    // One clock edge of the model, all updates from pre-edge values
    task automatic model_step();
        rand_words_t   w;
        in_bits_t      sb;
        integ_bits_t   ib;
        integ_values_t nxt;
        w = make_words(m_lfsr);
        sb.a = m_in.a > w.in_a;
        sb.b = m_in.b > w.in_b;
        ib.a = m_cnt.a > w.integ_a;
        ib.b = m_cnt.b > w.integ_b;
        nxt.a = step_count(m_cnt.a, sb.a, sb.b);
        nxt.b = step_count(m_cnt.b, ib.a, sb.b);  // b drains every stage
        nxt.c = step_count(m_cnt.c, ib.b, sb.b);
        if (m_pos == '0) begin
            m_latch = m_cnt;
            m_out = {m_cnt.a[0], m_cnt.b[0], m_cnt.c[0]};
        end else if (m_pos == LAST_POS) begin
            m_out = '0;
        end else begin
            m_out = {m_latch.a[m_pos], m_latch.b[m_pos], m_latch.c[m_pos]};
        end
        if (m_pos == LAST_POS) begin
            m_in.a = m_shift_a;  // Capture, dummy dropped
            m_in.b = m_shift_b;
        end else begin
            m_shift_a = {ser_in.a, m_shift_a[`VALUE_W-1:1]};
            m_shift_b = {ser_in.b, m_shift_b[`VALUE_W-1:1]};
        end
        m_cnt  = nxt;
        m_lfsr = {m_lfsr[`LFSR_W-2:0], m_lfsr[`LFSR_TAP_HI] ^ m_lfsr[`LFSR_TAP_LO]};
        m_pos  = (m_pos == LAST_POS) ? '0 : frame_pos_t'(m_pos + 1'b1);
    endtask

    always @(posedge clk) begin
        if (rst_n) model_reset();
        else model_step();
    end

    task automatic check_bits(input string name, input integ_bits_t exp, input integ_bits_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_value(input string name, input value_t exp, input value_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic fail_note(input string text);
        n_errors++;
        $display("At %0t: %s", $time, text);
    endtask

    // Called at a falling edge, returns at the next one with outputs checked
    task automatic run_cycle(input in_bits_t bits);
        int          idx;
        rand_words_t w;
        ser_in = bits;
        @(posedge clk);
        @(negedge clk);
        w = make_words(m_lfsr);  // Words in effect after the edge
        check_bits("ser_out", m_out, ser_out);
        check_bit("sn_c", m_cnt.c > w.integ_c, sn_c);
        if (expect_quiet) begin
            check_bits("ser_out quiet", '0, ser_out);
            check_bit("sn_c quiet", 1'b0, sn_c);
        end
        if (m_pos != '0) begin
            idx = int'(m_pos) - 1;  // Bit sent after the previous edge
            rx_frame.a[idx] = ser_out.a;
            rx_frame.b[idx] = ser_out.b;
            rx_frame.c[idx] = ser_out.c;
        end
        if (m_pos == LAST_POS) begin  // All nine bits in
            check_value("frame a", m_latch.a, rx_frame.a);
            check_value("frame b", m_latch.b, rx_frame.b);
            check_value("frame c", m_latch.c, rx_frame.c);
            last_frame = rx_frame;
        end
    endtask

    task automatic drive_frame(input value_t a, input value_t b);
        if (m_pos != '0) fail_note("input frame does not start at frame position 0");
        for (int k = 0; k < `FRAME_LEN; k++) run_cycle(frame_bits(a, b, k));
    endtask

    task automatic end_test(input string name, input int err_start);
        n_tests++;
        $display("Test %s: %s, %0d errors", name,
                 (n_errors == err_start) ? "ok" : "failed", n_errors - err_start);
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = n_errors;
        repeat (3) begin
            @(negedge clk);
            check_bits("ser_out in reset", '0, ser_out);
            check_bit("sn_c in reset", 1'b0, sn_c);
        end
        rst_n = 1'b0;  // Release on falling edge
        expect_quiet = 1'b1;
        repeat (2) drive_frame('0, '0);
        expect_quiet = 1'b0;
        end_test("reset_state", e0);
    endtask

    task automatic test_zero_hold();
        int e0;
        e0 = n_errors;
        expect_quiet = 1'b1;
        repeat (20) begin
            drive_frame('0, '0);
            check_value("zero frame a", '0, last_frame.a);
            check_value("zero frame b", '0, last_frame.b);
            check_value("zero frame c", '0, last_frame.c);
        end
        expect_quiet = 1'b0;
        end_test("zero_hold", e0);
    endtask

    task automatic test_ramp();
        int     e0;
        value_t prev;
        e0 = n_errors;
        prev = last_frame.a;
        repeat (60) begin
            drive_frame(value_t'(500), '0);
            if (last_frame.a < prev) fail_note("channel a frame went down during ramp");
            prev = last_frame.a;
        end
        end_test("ramp", e0);
    endtask

    task automatic test_saturation();
        int   e0;
        logic reached;
        e0 = n_errors;
        reached = 1'b0;
        repeat (70) begin
            drive_frame(MAX_VAL, '0);
            if (reached) check_value("frame a held at max", MAX_VAL, last_frame.a);
            if (last_frame.a == MAX_VAL) reached = 1'b1;
        end
        if (!reached) fail_note("channel a never reached the upper limit in 70 frames");
        end_test("saturation", e0);
    endtask

    // A counter moves at most one step per clock, so a larger jump is a wrap
    function automatic logic jump_ok(input value_t prev, input value_t cur);
        int d;
        d = int'(cur) - int'(prev);
        return (d <= `FRAME_LEN) && (d >= -`FRAME_LEN);
    endfunction

    task automatic test_decay();
        int            e0, n;
        integ_values_t prev;
        e0 = n_errors;
        n = 0;
        prev = last_frame;
        while (n < 250 && (n < 80 || last_frame != '0)) begin  // Drain, bounded
            drive_frame('0, value_t'(400));
            if (!jump_ok(prev.a, last_frame.a) || !jump_ok(prev.b, last_frame.b) ||
                !jump_ok(prev.c, last_frame.c)) begin
                fail_note("output frame jumped more than one frame of steps");
            end
            prev = last_frame;
            n++;
        end
        if (last_frame != '0) fail_note("channels did not drain to 0 within 250 frames");
        end_test("decay", e0);
    endtask

    task automatic test_framing();
        int         e0;
        value_t     new_a, new_b;
        in_values_t old;
        e0 = n_errors;
        repeat (6) begin
            new_a = value_t'($random(seed));
            new_b = value_t'($random(seed));
            old = m_in;  // Values in effect before this frame
            for (int k = 0; k < `VALUE_W; k++) run_cycle(frame_bits(new_a, new_b, k));
            check_value("in_values.a before capture", old.a, UUT.in_values.a);
            check_value("in_values.b before capture", old.b, UUT.in_values.b);
            run_cycle('0);  // Dummy slot, capture edge
            check_value("in_values.a captured", new_a, UUT.in_values.a);
            check_value("in_values.b captured", new_b, UUT.in_values.b);
        end
        end_test("framing", e0);
    endtask

    initial begin
        rst_n = 1'b1;
        ser_in = '0;
        expect_quiet = 1'b0;
        rx_frame = '0;
        last_frame = '0;
        m_shift_a = '0;
        m_shift_b = '0;
        n_checks = 0;
        n_errors = 0;
        n_tests = 0;
        n_cycles = 0;
        model_reset();
        test_reset_state();
        test_zero_hold();
        test_ramp();
        test_saturation();
        test_decay();
        test_framing();
        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/stoch_pkg.sv
source/frame_control.sv
source/serial_deserializer.sv
source/lfsr_source.sv
source/sat_updown_counter.sv
source/integrator_chain.sv
source/serial_serializer.sv
source/stoch_integrator_top.sv
sim/stoch_integrator_properties.sv
sim/stoch_integrator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator and run, pass decided by the printed pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module stoch_integrator_tb -f build.f -o stoch_sim \
    || { echo "Verilator build failed"; exit 1; }

result="$(./obj_dir/stoch_sim 2>&1)"
echo "$result"
echo "$result" | grep -qx "TESTS PASSED" && exit 0 || exit 1
